/* common/md_defines.svh */
`ifndef MD_DEFINES_SVH
`define MD_DEFINES_SVH

// Operand and HI/LO word width
`define MD_DATA_W 32

// Width of the operation code
`define MD_FUNCT_W 6

// Iterations per multiply or divide
`define MD_ITER_N 32

// MIPS SPECIAL funct encodings
`define MD_FUNCT_MTHI  6'b010001
`define MD_FUNCT_MTLO  6'b010011
`define MD_FUNCT_MULT  6'b011000
`define MD_FUNCT_MULTU 6'b011001
`define MD_FUNCT_DIV   6'b011010
`define MD_FUNCT_DIVU  6'b011011

`endif

/* common/md_pkg.sv */
`include "md_defines.svh"

package md_pkg;

  // Kept operations, encoded by their funct field
  typedef enum logic [`MD_FUNCT_W-1:0] {
    OP_MTHI  = `MD_FUNCT_MTHI,
    OP_MTLO  = `MD_FUNCT_MTLO,
    OP_MULT  = `MD_FUNCT_MULT,
    OP_MULTU = `MD_FUNCT_MULTU,
    OP_DIV   = `MD_FUNCT_DIV,
    OP_DIVU  = `MD_FUNCT_DIVU
  } md_op_e;

  typedef struct packed {
    md_op_e                op;
    logic [`MD_DATA_W-1:0] operand_1;
    logic [`MD_DATA_W-1:0] operand_2;
  } md_cmd_t;

  typedef struct packed {
    logic [`MD_DATA_W-1:0] hi;
    logic [`MD_DATA_W-1:0] lo;
  } hilo_t;

  // Result of one operation, full pair as it stands afterwards
  typedef struct packed {
    md_op_e op;
    hilo_t  hilo;
  } md_rsp_t;

endpackage

/* logic/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic arst_n_i,
  input  logic flush_i,
  // Upstream side
  input  logic in_valid_i,
  output logic in_ready_o,
  input  T     in_data_i,
  // Downstream side
  output logic out_valid_o,
  input  logic out_ready_i,
  output T     out_data_o
);

  logic full_q;
  logic in_fire;
  T     data_q;

  // Accept when empty or when the held entry leaves this cycle
  assign in_ready_o = !full_q || out_ready_i;
  assign in_fire    = in_valid_i && in_ready_o;

  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (flush_i) begin
      full_q <= 1'b0;
    end else if (in_fire) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      data_q <= in_data_i;
    end
  end

endmodule

/* logic/hilo_file.sv */
`timescale 1ns/1ps

module hilo_file (
  input  logic          clk,
  input  logic          arst_n_i,
  input  logic          wr_pending_i,
  input  logic          wr_accept_i,
  input  md_pkg::hilo_t wr_hilo_i,
  output md_pkg::hilo_t rd_hilo_o
);

  import md_pkg::*;

  hilo_t hilo_q;

  // Architectural state, zero out of reset
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hilo_q <= '0;
    end else if (wr_pending_i && wr_accept_i) begin
      hilo_q <= wr_hilo_i;
    end
  end

  // A retiring pair is newer than the stored one
  assign rd_hilo_o = wr_pending_i ? wr_hilo_i : hilo_q;

endmodule

/* multdiv/md_cycle_counter.sv */
`timescale 1ns/1ps

`include "md_defines.svh"

module md_cycle_counter (
  input  logic clk,
  input  logic arst_n_i,
  input  logic load_i,
  input  logic run_i,
  output logic last_o
);

  localparam int CNT_W = $clog2(`MD_ITER_N);

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= CNT_W'(`MD_ITER_N - 1);
    end else if (run_i && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Zero count marks the final iteration
  assign last_o = (cnt_q == '0);

endmodule

/* multdiv/md_ctrl_fsm.sv */
`timescale 1ns/1ps

module md_ctrl_fsm (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            flush_i,
  // Command from the input buffer
  input  logic            cmd_valid_i,
  output logic            cmd_ready_o,
  input  md_pkg::md_cmd_t cmd_i,
  // Status from datapath and counter
  input  logic            div_zero_i,
  input  logic            last_i,
  // Datapath and counter control
  output logic            cnt_load_o,
  output logic            step_o,
  output logic            start_o,
  output logic            finish_o,
  // Response towards the output buffer
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i,
  output md_pkg::md_op_e  op_o
);

  import md_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ITER,
    FIX,
    DONE
  } state_e;

  state_e state_q, state_d;
  md_op_e op_q;
  logic   take;
  logic   short_op;

  assign cmd_ready_o = (state_q == IDLE);
  assign take        = cmd_valid_i && cmd_ready_o;

  // Moves to HI/LO and division by zero need no iterations
  assign short_op = (cmd_i.op == OP_MTHI) || (cmd_i.op == OP_MTLO) || div_zero_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: if (take) state_d = short_op ? DONE : ITER;
      ITER: if (last_i) state_d = FIX;
      FIX:  state_d = DONE;
      DONE: if (rsp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
    // Flush drops whatever is in progress
    if (flush_i) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      op_q <= cmd_i.op;
    end
  end

  assign start_o     = take;
  assign cnt_load_o  = take;
  assign step_o      = (state_q == ITER);
  assign finish_o    = (state_q == FIX);
  assign rsp_valid_o = (state_q == DONE);
  assign op_o        = op_q;

endmodule

/* multdiv/md_datapath.sv */
`timescale 1ns/1ps

`include "md_defines.svh"

module md_datapath (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            start_i,
  input  logic            step_i,
  input  logic            finish_i,
  input  md_pkg::md_cmd_t cmd_i,
  input  md_pkg::hilo_t   hilo_i,
  output logic            div_zero_o,
  output md_pkg::hilo_t   hilo_o
);

  import md_pkg::*;

  localparam int W = `MD_DATA_W;

  // Product, or remainder in the upper half and quotient in the lower
  logic [2*W-1:0] acc_q;
  logic [2*W-1:0] acc_start;
  logic [2*W-1:0] acc_step;
  logic [2*W-1:0] acc_fix;
  // Multiplicand or divisor magnitude
  logic [W-1:0]   op2_q;
  logic           is_div_q;
  logic           neg_res_q;
  logic           neg_rem_q;

  logic           is_div;
  logic           is_signed;
  logic           neg_a;
  logic           neg_b;
  logic [W-1:0]   mag_a;
  logic [W-1:0]   mag_b;
  logic [W:0]     sum;
  logic [W:0]     rem_sh;
  logic [W:0]     diff;

  assign is_div    = (cmd_i.op == OP_DIV) || (cmd_i.op == OP_DIVU);
  assign is_signed = (cmd_i.op == OP_MULT) || (cmd_i.op == OP_DIV);
  assign neg_a     = is_signed && cmd_i.operand_1[W-1];
  assign neg_b     = is_signed && cmd_i.operand_2[W-1];
  assign mag_a     = neg_a ? -cmd_i.operand_1 : cmd_i.operand_1;
  assign mag_b     = neg_b ? -cmd_i.operand_2 : cmd_i.operand_2;

  assign div_zero_o = is_div && (cmd_i.operand_2 == '0);

  always_comb begin
    unique case (cmd_i.op)
      OP_MTHI: acc_start = {cmd_i.operand_1, hilo_i.lo};
      OP_MTLO: acc_start = {hilo_i.hi, cmd_i.operand_1};
      default: acc_start = div_zero_o ? hilo_i : {{W{1'b0}}, mag_a};
    endcase
  end

  always_comb begin
    // Shift-add, multiplier bits leave at the bottom
    sum    = {1'b0, acc_q[2*W-1:W]} + {1'b0, op2_q & {W{acc_q[0]}}};
    // Restoring step on the left-shifted remainder
    rem_sh = acc_q[2*W-1:W-1];
    diff   = rem_sh - {1'b0, op2_q};
    if (is_div_q) begin
      if (diff[W]) begin
        acc_step = {rem_sh[W-1:0], acc_q[W-2:0], 1'b0};
      end else begin
        acc_step = {diff[W-1:0], acc_q[W-2:0], 1'b1};
      end
    end else begin
      acc_step = {sum, acc_q[W-1:1]};
    end
  end

  // Remainder takes the dividend's sign, a product is negated whole
  always_comb begin
    if (is_div_q) begin
      acc_fix[2*W-1:W] = neg_rem_q ? -acc_q[2*W-1:W] : acc_q[2*W-1:W];
      acc_fix[W-1:0]   = neg_res_q ? -acc_q[W-1:0] : acc_q[W-1:0];
    end else begin
      acc_fix = neg_res_q ? -acc_q : acc_q;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      acc_q <= acc_start;
      op2_q <= mag_b;
    end else if (step_i) begin
      acc_q <= acc_step;
    end else if (finish_i) begin
      acc_q <= acc_fix;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      is_div_q  <= 1'b0;
      neg_res_q <= 1'b0;
      neg_rem_q <= 1'b0;
    end else if (start_i) begin
      is_div_q  <= is_div;
      neg_res_q <= neg_a ^ neg_b;
      neg_rem_q <= neg_a;
    end
  end

  assign hilo_o = hilo_t'(acc_q);

endmodule

/* logic/md_unit_top.sv */
`timescale 1ns/1ps

module md_unit_top (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            flush_i,
  // Command channel
  input  logic            cmd_valid_i,
  output logic            cmd_ready_o,
  input  md_pkg::md_cmd_t cmd_i,
  // Response channel
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i,
  output md_pkg::md_rsp_t rsp_o
);

  import md_pkg::*;

  logic    q_valid;
  logic    fsm_cmd_ready;
  md_cmd_t q_cmd;

  logic    div_zero;
  logic    cnt_last;
  logic    cnt_load;
  logic    dp_step;
  logic    dp_start;
  logic    dp_finish;

  logic    fsm_rsp_valid;
  logic    rbuf_in_ready;
  md_op_e  fsm_op;
  hilo_t   dp_hilo;
  hilo_t   rd_hilo;
  md_rsp_t fsm_rsp;

  assign fsm_rsp = '{op: fsm_op, hilo: dp_hilo};

  stage_reg #(.T(md_cmd_t)) u_cmd_buf (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (cmd_valid_i),
    .in_ready_o  (cmd_ready_o),
    .in_data_i   (cmd_i),
    .out_valid_o (q_valid),
    .out_ready_i (fsm_cmd_ready),
    .out_data_o  (q_cmd)
  );

  md_ctrl_fsm u_ctrl (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .flush_i     (flush_i),
    .cmd_valid_i (q_valid),
    .cmd_ready_o (fsm_cmd_ready),
    .cmd_i       (q_cmd),
    .div_zero_i  (div_zero),
    .last_i      (cnt_last),
    .cnt_load_o  (cnt_load),
    .step_o      (dp_step),
    .start_o     (dp_start),
    .finish_o    (dp_finish),
    .rsp_valid_o (fsm_rsp_valid),
    .rsp_ready_i (rbuf_in_ready),
    .op_o        (fsm_op)
  );

  md_cycle_counter u_cnt (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .load_i   (cnt_load),
    .run_i    (dp_step),
    .last_o   (cnt_last)
  );

  md_datapath u_dp (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .start_i    (dp_start),
    .step_i     (dp_step),
    .finish_i   (dp_finish),
    .cmd_i      (q_cmd),
    .hilo_i     (rd_hilo),
    .div_zero_o (div_zero),
    .hilo_o     (dp_hilo)
  );

  // Finished results are never flushed
  stage_reg #(.T(md_rsp_t)) u_rsp_buf (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .flush_i     (1'b0),
    .in_valid_i  (fsm_rsp_valid),
    .in_ready_o  (rbuf_in_ready),
    .in_data_i   (fsm_rsp),
    .out_valid_o (rsp_valid_o),
    .out_ready_i (rsp_ready_i),
    .out_data_o  (rsp_o)
  );

  hilo_file u_hilo (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .wr_pending_i (rsp_valid_o),
    .wr_accept_i  (rsp_ready_i),
    .wr_hilo_i    (rsp_o.hilo),
    .rd_hilo_o    (rd_hilo)
  );

endmodule

/* verification/md_tests.svh */
task automatic reset_values();
  int                    err_start;
  logic [`MD_DATA_W-1:0] x;
  err_start = errors;
  check_flag("rsp_valid_o", rsp_valid_o, 1'b0);
  check_flag("cmd_ready_o", cmd_ready_o, 1'b1);
  x = $random(seed);
  // Zero divisor shows the reset pair
  do_op(OP_DIVU, x, '0);
  // LO must still read zero
  do_op(OP_MTHI, x, '0);
  finish_test("reset_values", err_start);
endtask

task automatic mult_products();
  int                    err_start;
  int                    i;
  logic [`MD_DATA_W-1:0] edge_val [5];
  logic [`MD_DATA_W-1:0] a;
  logic [`MD_DATA_W-1:0] b;
  err_start = errors;
  edge_val  = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
  for (i = 0; i < 5; i++) begin
    do_op(OP_MULT, edge_val[i], edge_val[4-i]);
    do_op(OP_MULTU, edge_val[i], edge_val[(i+2)%5]);
  end
  do_op(OP_MULT, 32'h8000_0000, 32'h8000_0000);
  do_op(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff);
  for (i = 0; i < 8; i++) begin
    a = $random(seed);
    b = $random(seed);
    do_op(i[0] ? OP_MULTU : OP_MULT, a, b);
  end
  finish_test("mult_products", err_start);
endtask

task automatic div_quotients();
  int                    err_start;
  int                    i;
  logic [`MD_DATA_W-1:0] a;
  logic [`MD_DATA_W-1:0] b;
  err_start = errors;
  // Signs of quotient and remainder
  do_op(OP_DIV, 32'hffff_fff9, 32'h2);
  do_op(OP_DIV, 32'h7, 32'hffff_fffe);
  do_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
  do_op(OP_DIVU, 32'hffff_ffff, 32'h1);
  do_op(OP_DIVU, 32'h5, 32'h9);
  // Zero divisor keeps HI/LO
  a = $random(seed);
  do_op(OP_DIV, a, '0);
  do_op(OP_DIVU, a, '0);
  for (i = 0; i < 8; i++) begin
    a = $random(seed);
    b = $random(seed);
    b = b >> (4 * i);
    do_op(i[0] ? OP_DIVU : OP_DIV, a, b);
  end
  finish_test("div_quotients", err_start);
endtask

task automatic hilo_moves();
  int                    err_start;
  logic [`MD_DATA_W-1:0] a;
  logic [`MD_DATA_W-1:0] b;
  err_start = errors;
  a = $random(seed);
  b = $random(seed);
  do_op(OP_MULTU, a, b);
  a = $random(seed);
  do_op(OP_MTHI, a, '0);
  b = $random(seed);
  do_op(OP_MTLO, b, '0);
  finish_test("hilo_moves", err_start);
endtask

task automatic backpressure_order();
  int                    err_start;
  int                    i;
  md_op_e                ops [3];
  logic [`MD_DATA_W-1:0] op1 [3];
  logic [`MD_DATA_W-1:0] op2 [3];
  hilo_t                 exp [3];
  err_start = errors;
  // MTLO takes its HI from the MULT still waiting at the output
  ops = '{OP_MULT, OP_MTLO, OP_DIVU};
  for (i = 0; i < 3; i++) begin
    op1[i]     = $random(seed);
    op2[i]     = $random(seed) | 32'h1;
    exp[i]     = expected_hilo(ops[i], op1[i], op2[i], model_hilo);
    model_hilo = exp[i];
    send_cmd(ops[i], op1[i], op2[i]);
  end
  check_flag("cmd_ready_o", cmd_ready_o, 1'b0);
  check_flag("rsp_valid_o", rsp_valid_o, 1'b1);
  for (i = 0; i < 3; i++) begin
    collect_rsp(ops[i], exp[i]);
  end
  finish_test("backpressure_order", err_start);
endtask

task automatic flush_cancel();
  int                    err_start;
  int                    i;
  logic                  stray;
  logic [`MD_DATA_W-1:0] a;
  logic [`MD_DATA_W-1:0] b;
  err_start = errors;
  a = $random(seed);
  b = $random(seed) | 32'h1;
  send_cmd(OP_DIV, a, b);
  // A second command waits in the input buffer
  send_cmd(OP_MULT, b, a);
  // Let the divide get into its iterations
  repeat (4) @(negedge clk);
  flush_i = 1'b1;
  @(negedge clk);
  flush_i = 1'b0;
  a = $random(seed);
  do_op(OP_MTHI, a, '0);
  stray = 1'b0;
  for (i = 0; i < `MD_ITER_N + 8; i++) begin
    @(negedge clk);
    if (rsp_valid_o) begin
      stray = 1'b1;
    end
  end
  check_flag("rsp_valid_o", stray, 1'b0);
  finish_test("flush_cancel", err_start);
endtask

/* verification/tb_md_unit.sv */
`timescale 1ns/1ps

`include "md_defines.svh"

module tb_md_unit;

  import md_pkg::*;

  localparam int WAIT_LIMIT = 200;

  logic    clk;
  logic    arst_n_i;
  logic    flush_i;
  logic    cmd_valid_i;
  logic    cmd_ready_o;
  md_cmd_t cmd_i;
  logic    rsp_valid_o;
  logic    rsp_ready_i;
  md_rsp_t rsp_o;

  integer  seed;
  int      checks;
  int      errors;
  int      tests_run;
  int      tests_failed;
  // Architectural HI/LO as the reference sees it
  hilo_t   model_hilo;

  md_unit_top u_md_unit_top (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .flush_i     (flush_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_i       (cmd_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
  );

  always #10 clk = ~clk;

  task automatic check_hilo(string sig, hilo_t got, hilo_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got hi %h lo %h, expected hi %h lo %h",
               sig, got.hi, got.lo, exp.hi, exp.lo);
    end
  endtask

  task automatic check_rsp_op(string sig, md_op_e got, md_op_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h expected %h", sig, got, exp);
    end
  endtask

  task automatic check_flag(string sig, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h expected %h", sig, got, exp);
    end
  endtask

  // HI/LO after one operation, from the MIPS multiply/divide rules
  function automatic hilo_t expected_hilo(md_op_e op, logic [`MD_DATA_W-1:0] a,
                                          logic [`MD_DATA_W-1:0] b, hilo_t prev);
    longint                  sa;
    longint                  sb;
    logic [2*`MD_DATA_W-1:0] wide;
    hilo_t                   res;
    sa  = $signed(a);
    sb  = $signed(b);
    res = prev;
    case (op)
      OP_MULT:  res = hilo_t'(sa * sb);
      OP_MULTU: begin
        wide = {{`MD_DATA_W{1'b0}}, a} * {{`MD_DATA_W{1'b0}}, b};
        res  = hilo_t'(wide);
      end
      OP_DIV: begin
        if (b != '0) begin
          wide   = sa / sb;
          res.lo = wide[`MD_DATA_W-1:0];
          wide   = sa % sb;
          res.hi = wide[`MD_DATA_W-1:0];
        end
      end
      OP_DIVU: begin
        if (b != '0) begin
          res.lo = a / b;
          res.hi = a % b;
        end
      end
      OP_MTHI: res.hi = a;
      OP_MTLO: res.lo = a;
      default: res = prev;
    endcase
    return res;
  endfunction

  // Called right after a falling edge, returns after the transfer
  task automatic send_cmd(md_op_e op, logic [`MD_DATA_W-1:0] a, logic [`MD_DATA_W-1:0] b);
    int n;
    n           = 0;
    cmd_valid_i = 1'b1;
    cmd_i       = '{op: op, operand_1: a, operand_2: b};
    while (!cmd_ready_o && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_ready_o) begin
      errors++;
      $display("Timeout: command was not accepted within %0d cycles", WAIT_LIMIT);
    end else begin
      @(negedge clk);
    end
    cmd_valid_i = 1'b0;
  endtask

  task automatic collect_rsp(md_op_e op, hilo_t exp);
    int n;
    n           = 0;
    rsp_ready_i = 1'b1;
    while (!rsp_valid_o && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!rsp_valid_o) begin
      errors++;
      $display("Timeout: no response arrived within %0d cycles", WAIT_LIMIT);
    end else begin
      check_rsp_op("rsp_o.op", rsp_o.op, op);
      check_hilo("rsp_o.hilo", rsp_o.hilo, exp);
      @(negedge clk);
    end
    rsp_ready_i = 1'b0;
  endtask

  task automatic do_op(md_op_e op, logic [`MD_DATA_W-1:0] a, logic [`MD_DATA_W-1:0] b);
    hilo_t exp;
    exp = expected_hilo(op, a, b, model_hilo);
    send_cmd(op, a, b);
    collect_rsp(op, exp);
    model_hilo = exp;
  endtask

  task automatic finish_test(string name, int err_start);
    tests_run++;
    if (errors != err_start) begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - err_start);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  `include "md_tests.svh"

  initial begin
    seed         = 32'h2c87078c;
    clk          = 1'b0;
    arst_n_i     = 1'b0;
    flush_i      = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_i        = '{op: OP_MTHI, operand_1: '0, operand_2: '0};
    rsp_ready_i  = 1'b0;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    model_hilo   = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;

    reset_values();
    mult_products();
    div_quotients();
    hilo_moves();
    backpressure_order();
    flush_cancel();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+common
+incdir+verification
common/md_pkg.sv
logic/stage_reg.sv
logic/hilo_file.sv
multdiv/md_cycle_counter.sv
multdiv/md_ctrl_fsm.sv
multdiv/md_datapath.sv
logic/md_unit_top.sv
verification/tb_md_unit.sv

/* Bender.yml */
package:
  name: md_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/md_pkg.sv
      - logic/stage_reg.sv
      - logic/hilo_file.sv
      - multdiv/md_cycle_counter.sv
      - multdiv/md_ctrl_fsm.sv
      - multdiv/md_datapath.sv
      - logic/md_unit_top.sv
  - target: test
    include_dirs:
      - common
      - verification
    files:
      - verification/tb_md_unit.sv
